// ==== la_cfg_pkg.sv ====
package la_cfg_pkg;

    // sample word and capture buffer sizing
    localparam int WORD_W    = 16;   // bits per sample word
    localparam int BUF_DEPTH = 256;  // words held in the capture buffer
    localparam int ADDR_W    = 8;    // buffer address width

    // words written after the trigger before the buffer freezes
    // leaves BUF_DEPTH - POST_TRIG words of pre-trigger history
    localparam int POST_TRIG = 192;

    // uart bit time, kept short for simulation
    // at 48 MHz / 1200 baud this would be 40000 and BIT_CNT_W would grow to 16
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = 5;  // wide enough for CLKS_PER_BIT - 1

endpackage

// ==== la_types_pkg.sv ====
package la_types_pkg;

    import la_cfg_pkg::*;

    // one packed sample word and its strobe
    // produced by the sampler once every WORD_W clocks
    typedef struct packed {
        logic              valid;  // high for one cycle per word
        logic [WORD_W-1:0] data;   // first sample in the msb
    } word_beat_t;

    // one byte on its way to the uart
    typedef logic [7:0] byte_t;

endpackage

// ==== bit_sampler.sv ====
`timescale 1ns/1ps

module bit_sampler
    import la_cfg_pkg::*;
    import la_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sig,
    output word_beat_t beat
);

    logic [3:0]        phase;  // sample index within the word
    logic [WORD_W-1:0] shreg;
    logic [WORD_W-1:0] next_word;

    assign next_word = {shreg[WORD_W-2:0], sig};

    always_ff @(posedge clk) begin
        shreg <= next_word;  // oldest sample ends up in the msb
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase      <= '0;
            beat.valid <= 1'b0;
        end else begin
            phase      <= phase + 1'b1;
            beat.valid <= 1'b0;
            if (phase == 4'hf) begin  // 16th sample of the group
                beat.valid <= 1'b1;
                beat.data  <= next_word;
            end
        end
    end

endmodule

// ==== capture_buffer.sv ====
`timescale 1ns/1ps

module capture_buffer
    import la_cfg_pkg::*;
    import la_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              trig,
    input  word_beat_t        beat,
    output logic [WORD_W-1:0] dump_word,
    output logic              dump_valid,
    input  logic              dump_ready
);

    typedef enum logic [1:0] {
        ST_ARMED,
        ST_POST,
        ST_DUMP
    } state_t;

    state_t            state;
    logic [WORD_W-1:0] mem [BUF_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] wr_next;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] post_cnt;
    logic              trig_s1;
    logic              trig_s2;
    logic              trig_d;
    logic              trig_rise;
    logic              wr_en;
    logic              rd_en;
    logic              rd_pend;
    logic              post_done;
    logic              dump_last;

    assign wr_next   = wr_ptr + 1'b1;
    assign trig_rise = trig_s2 & ~trig_d;
    assign wr_en     = beat.valid && (state != ST_DUMP);  // dropped while dumping
    assign rd_en     = (state == ST_DUMP) && !dump_valid && !rd_pend;
    assign post_done = wr_en && (post_cnt == ADDR_W'(POST_TRIG - 1));
    assign dump_last = ADDR_W'(rd_ptr + 1'b1) == wr_ptr;  // walked all the way round

    always_ff @(posedge clk) begin
        if (!rst) begin
            trig_s1 <= 1'b0;
            trig_s2 <= 1'b0;
            trig_d  <= 1'b0;
        end else begin
            trig_s1 <= trig;  // trig is asynchronous to clk
            trig_s2 <= trig_s1;
            trig_d  <= trig_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= beat.data;
        end
        if (rd_en) begin
            dump_word <= mem[rd_ptr];  // one cycle read port
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= ST_ARMED;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            post_cnt   <= '0;
            rd_pend    <= 1'b0;
            dump_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_next;
            end
            case (state)
                ST_ARMED: begin
                    if (trig_rise) begin
                        state    <= ST_POST;
                        post_cnt <= '0;
                    end
                end
                ST_POST: begin
                    if (wr_en) begin
                        post_cnt <= post_cnt + 1'b1;
                    end
                    if (post_done) begin
                        state  <= ST_DUMP;
                        rd_ptr <= wr_next;  // oldest word once this write lands
                    end
                end
                ST_DUMP: begin
                    if (rd_en) begin
                        rd_pend <= 1'b1;
                    end
                    if (rd_pend) begin
                        rd_pend    <= 1'b0;
                        dump_valid <= 1'b1;
                    end
                    if (dump_valid && dump_ready) begin
                        dump_valid <= 1'b0;
                        rd_ptr     <= rd_ptr + 1'b1;
                        if (dump_last) begin
                            state <= ST_ARMED;  // re-arm, capture resumes
                        end
                    end
                end
                default: state <= ST_ARMED;
            endcase
        end
    end

endmodule

// ==== word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer
    import la_cfg_pkg::*;
    import la_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] dump_word,
    input  logic              dump_valid,
    output logic              dump_ready,
    output byte_t             byte_data,
    output logic              byte_valid,
    input  logic              byte_ready
);

    logic [WORD_W-1:0] hold_word;
    logic              hi_sel;  // high byte is on the output

    assign dump_ready = !byte_valid;  // only take a word when empty
    assign byte_data  = hi_sel ? byte_t'(hold_word[15:8]) : byte_t'(hold_word[7:0]);

    always_ff @(posedge clk) begin
        if (dump_valid && dump_ready) begin
            hold_word <= dump_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            byte_valid <= 1'b0;
            hi_sel     <= 1'b0;
        end else if (dump_valid && dump_ready) begin
            byte_valid <= 1'b1;
            hi_sel     <= 1'b0;  // low byte first
        end else if (byte_valid && byte_ready) begin
            if (hi_sel) begin
                byte_valid <= 1'b0;
                hi_sel     <= 1'b0;
            end else begin
                hi_sel <= 1'b1;
            end
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import la_cfg_pkg::*;
    import la_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t byte_data,
    input  logic  byte_valid,
    output logic  byte_ready,
    output logic  tx
);

    logic [BIT_CNT_W-1:0] bit_cnt;  // clocks into the current bit
    logic [3:0]           bit_idx;  // 0 start, 1..8 data, 9 stop
    logic [9:0]           frame;    // shifts out lsb first
    logic                 busy;
    logic                 bit_end;

    assign byte_ready = !busy;
    assign tx         = frame[0];  // all ones while idle
    assign bit_end    = bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
            frame   <= '1;
        end else if (!busy) begin
            if (byte_valid) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                bit_idx <= '0;
                frame   <= {1'b1, byte_data, 1'b0};  // stop, data, start
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_end) begin
                bit_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                frame   <= {1'b1, frame[9:1]};
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;  // stop bit done
                end
            end
        end
    end

endmodule

// ==== hex_dump_top.sv ====
`timescale 1ns/1ps

module hex_dump_top
    import la_cfg_pkg::*;
    import la_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sig,
    input  logic trig,
    output logic tx
);

    word_beat_t        beat;
    logic [WORD_W-1:0] dump_word;
    logic              dump_valid;
    logic              dump_ready;
    byte_t             byte_data;
    logic              byte_valid;
    logic              byte_ready;

    bit_sampler bit_sampler_inst (
        .clk  (clk),
        .rst  (rst),
        .sig  (sig),
        .beat (beat)
    );

    capture_buffer capture_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .trig       (trig),
        .beat       (beat),
        .dump_word  (dump_word),
        .dump_valid (dump_valid),
        .dump_ready (dump_ready)
    );

    word_serializer word_serializer_inst (
        .clk        (clk),
        .rst        (rst),
        .dump_word  (dump_word),
        .dump_valid (dump_valid),
        .dump_ready (dump_ready),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready)
    );

    uart_tx uart_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .tx         (tx)
    );

endmodule

// ==== tb_hex_dump.sv ====
`timescale 1ns/1ps

module tb_hex_dump
    import la_cfg_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 6000;
    localparam int PRE_TRIG     = BUF_DEPTH - POST_TRIG;  // words kept before the trigger
    localparam int DUMP_CLKS    = 2 * BUF_DEPTH * 10 * CLKS_PER_BIT;
    localparam int CAPTURE_CLKS = IDLE_CYCLES + 2 * (POST_TRIG + BUF_DEPTH + 16) * WORD_W;
    localparam int CYCLE_LIMIT  = (2 * DUMP_CLKS + CAPTURE_CLKS) * 12 / 10;

    logic clk;
    logic rst;
    logic sig;
    logic trig;
    logic tx;

    logic [31:0]       rng;
    logic [WORD_W-1:0] cur_word;
    logic [WORD_W-1:0] model_words[$];  // every word the sampler should produce
    logic [WORD_W-1:0] rx_words[$];     // words decoded from the current dump
    int                sample_cnt;
    int                cycle_cnt;
    int                dumps_done;
    int                trig_words[2];   // model word holding each trigger point

    hex_dump_top hex_dump_top_inst (
        .clk  (clk),
        .rst  (rst),
        .sig  (sig),
        .trig (trig),
        .tx   (tx)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        abort_run($sformatf("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, dump never completed", cycle_cnt));
        end
    end

    // one clock of stimulus, inputs change 1 ns after the edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        if (cycle_cnt >= RESET_CYCLES) begin
            rst = 1'b1;
        end
        rng = next_random(rng);
        sig = rng[0];
        if (rst) begin  // sampled on the next edge
            cur_word   = {cur_word[WORD_W-2:0], sig};
            sample_cnt = sample_cnt + 1;
            if (sample_cnt % WORD_W == 0) begin
                model_words.push_back(cur_word);
            end
        end
    endtask

    task automatic raise_trigger(input int idx);
        while (sample_cnt % WORD_W != WORD_W / 2 + 1) begin
            advance_cycle();
        end
        trig            = 1'b1;  // mid window of the current word
        trig_words[idx] = (sample_cnt - 1) / WORD_W;
        repeat (64) advance_cycle();
        trig = 1'b0;
    endtask

    task automatic receive_byte(output logic [7:0] data);
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        assert (tx === 1'b0) else report_mismatch("tx start bit", 32'h0, tx);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;  // lsb first
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1) else report_mismatch("tx stop bit", 32'h1, tx);
    endtask

    task automatic check_dump(input int idx);
        int exp_start;
        int start;
        exp_start = trig_words[idx] - PRE_TRIG;
        start     = -1;
        assert (exp_start + BUF_DEPTH < model_words.size())
            else abort_run("dump finished before the sample model holds the frozen words");
        for (int off = -1; off <= 1; off++) begin
            if (start < 0 && model_words[exp_start + off] == rx_words[0]) begin
                start = exp_start + off;
            end
        end
        assert (start >= 0)
            else abort_run("first dumped word is not within one word of the trigger position");
        for (int i = 0; i < BUF_DEPTH; i++) begin
            assert (rx_words[i] === model_words[start + i])
                else report_mismatch("dump_word", model_words[start + i], rx_words[i]);
        end
    endtask

    initial begin
        logic [7:0] lo;
        logic [7:0] hi;
        forever begin
            receive_byte(lo);
            receive_byte(hi);
            rx_words.push_back({hi, lo});  // low byte comes first
            if (rx_words.size() == BUF_DEPTH) begin
                check_dump(dumps_done);
                rx_words.delete();
                dumps_done = dumps_done + 1;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        sig        = 1'b0;
        trig       = 1'b0;
        rng        = 32'ha2e0;
        cur_word   = '0;
        sample_cnt = 0;
        dumps_done = 0;
        repeat (RESET_CYCLES + IDLE_CYCLES) begin
            advance_cycle();
            assert (tx === 1'b1) else report_mismatch("tx", 32'h1, tx);  // no trigger yet
        end
        for (int d = 0; d < 2; d++) begin
            raise_trigger(d);
            while (dumps_done <= d) begin
                advance_cycle();
            end
            repeat ((BUF_DEPTH + 8) * WORD_W) advance_cycle();  // refill with new samples
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
la_cfg_pkg.sv
la_types_pkg.sv
bit_sampler.sv
capture_buffer.sv
word_serializer.sv
uart_tx.sv
hex_dump_top.sv
tb_hex_dump.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_hex_dump -f all.f --Mdir obj_dir
	-./obj_dir/Vtb_hex_dump 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --top-module hex_dump_top \
		la_cfg_pkg.sv la_types_pkg.sv bit_sampler.sv capture_buffer.sv \
		word_serializer.sv uart_tx.sv hex_dump_top.sv

clean:
	rm -rf obj_dir $(LOG)
